// File: hdl/norm_pkg.sv
/*
 * Shared types for the fixed-point row normalizer
 * Accumulators are 24 bits signed, enough for rows of up to 256 elements
 */
package norm_pkg;

    // Input and output element
    typedef logic signed [7:0] data_t;

    // Sums, squares, center and spread
    typedef logic signed [23:0] acc_t;

    // Floor square root of a 24-bit radicand
    typedef logic [11:0] root_t;

    typedef struct packed {
        acc_t center;
        acc_t spread;
    } stats_t;

    // Row controller
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        ROOT,
        EMIT
    } norm_state_t;

endpackage

// File: hdl/norm_row_buffer.sv
/*
 * Holds one row of beats between the load and emit phases
 * Read data is registered and follows rd_addr by one cycle
 */
module norm_row_buffer
    import norm_pkg::*;
#(
    parameter int ROW_LEN = 8,
    parameter int LANES = 2,
    localparam int DEPTH = ROW_LEN / LANES,
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              wr_en,
    input  logic [AW-1:0]     wr_addr,
    input  logic [AW-1:0]     rd_addr,
    input  data_t [LANES-1:0] wr_data,
    output data_t [LANES-1:0] rd_data
);

    data_t [LANES-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: hdl/norm_stats.sv
/*
 * Row statistics for layer or RMS normalization
 * ROW_LEN must be a power of two, the mean is a floor (arithmetic shift)
 */
module norm_stats
    import norm_pkg::*;
#(
    parameter int ROW_LEN = 8,
    parameter int LANES = 2,
    parameter NORM_TYPE = "LAYER_NORM"
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              beat_valid,
    input  data_t [LANES-1:0] beat,
    input  logic              last,
    output logic              stats_valid,
    output stats_t            stats
);

    localparam int SHIFT = $clog2(ROW_LEN);
    localparam bit IS_RMS = (NORM_TYPE == "RMS_NORM");

    acc_t sum_q;
    acc_t sq_q;
    acc_t sum_d;
    acc_t sq_d;
    stats_t stats_d;

    // Running totals including the current beat
    always_comb begin
        acc_t e;
        sum_d = sum_q;
        sq_d = sq_q;
        for (int i = 0; i < LANES; i++) begin
            e = acc_t'(beat[i]);
            sum_d = sum_d + e;
            sq_d = sq_d + e * e;
        end
    end

    always_comb begin
        acc_t mean;
        acc_t mean_sq;
        acc_t var_raw;
        mean = sum_d >>> SHIFT;
        mean_sq = sq_d >>> SHIFT;
        var_raw = mean_sq - mean * mean;
        if (IS_RMS) begin
            stats_d.center = '0;
            stats_d.spread = mean_sq;
        end else begin
            stats_d.center = mean;
            // Floor of the mean can push the variance slightly negative
            stats_d.spread = (var_raw < 0) ? '0 : var_raw;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_q <= '0;
            sq_q <= '0;
            stats_valid <= 1'b0;
        end else begin
            stats_valid <= beat_valid && last;
            if (beat_valid && last) begin
                sum_q <= '0;
                sq_q <= '0;
            end else if (beat_valid) begin
                sum_q <= sum_d;
                sq_q <= sq_d;
            end
        end
    end

    // Held until the next row completes
    always_ff @(posedge clk) begin
        if (beat_valid && last) begin
            stats <= stats_d;
        end
    end

endmodule

// File: hdl/norm_isqrt.sv
/*
 * Restoring bit-pair integer square root, one result bit per cycle
 * Radicand must be non-negative, root is valid from done until next start
 */
module norm_isqrt
    import norm_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  start,
    input  acc_t  radicand,
    output logic  done,
    output root_t root
);

    localparam int STEPS = $bits(root_t);
    localparam int RW = $bits(acc_t);

    logic [RW-1:0] rad_q;
    logic [STEPS+1:0] rem_q;
    logic [3:0] cnt_q;
    logic busy_q;

    logic [STEPS+1:0] rem_sh;
    logic [STEPS+1:0] trial;

    // Bring down the next bit pair and try 4*root+1
    always_comb begin
        rem_sh = {rem_q[STEPS-1:0], rad_q[RW-1 -: 2]};
        trial = {root, 2'b01};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rad_q <= '0;
            rem_q <= '0;
            cnt_q <= '0;
            busy_q <= 1'b0;
            done <= 1'b0;
            root <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                rad_q <= radicand;
                rem_q <= '0;
                root <= '0;
                cnt_q <= '0;
                busy_q <= 1'b1;
            end else if (busy_q) begin
                rad_q <= rad_q << 2;
                if (rem_sh >= trial) begin
                    rem_q <= rem_sh - trial;
                    root <= {root[STEPS-2:0], 1'b1};
                end else begin
                    rem_q <= rem_sh;
                    root <= {root[STEPS-2:0], 1'b0};
                end
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == 4'(STEPS - 1)) begin
                    busy_q <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/norm_scale.sv
/*
 * Replays the stored row and normalizes one element at a time
 * Each element takes 26 cycles, scale must be non-zero
 * The next beat is not started until the current one is accepted
 */
module norm_scale
    import norm_pkg::*;
#(
    parameter int ROW_LEN = 8,
    parameter int LANES = 2,
    localparam int DEPTH = ROW_LEN / LANES,
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1,
    localparam int LW = (LANES > 1) ? $clog2(LANES) : 1
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              row_go,
    input  acc_t              center,
    input  root_t             scale,
    output logic [AW-1:0]     rd_addr,
    input  data_t [LANES-1:0] rd_data,
    output data_t [LANES-1:0] out_data,
    output logic              out_valid,
    input  logic              out_ready,
    output logic              row_done
);

    localparam int QW = $bits(acc_t);
    localparam int SW = $bits(root_t);
    // Load, one shift per quotient bit, store
    localparam int DIV_STEPS = QW + 2;
    localparam data_t DATA_MAX = 8'sh7f;
    localparam data_t DATA_MIN = 8'sh80;

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_DIV,
        S_OUT
    } scale_state_t;

    scale_state_t state_q;
    acc_t center_q;
    root_t scale_q;
    logic [LW-1:0] lane_q;
    logic [4:0] step_q;
    logic neg_q;
    logic [QW-1:0] quo_q;
    logic [SW:0] rem_q;

    acc_t diff;
    logic [SW:0] rem_sh;
    acc_t quot;
    data_t sat;

    always_comb begin
        diff = (acc_t'(rd_data[lane_q]) - center_q) <<< 4;
        rem_sh = {rem_q[SW-1:0], quo_q[QW-1]};
        // Magnitude divide, sign restored for truncation toward zero
        quot = neg_q ? -acc_t'(quo_q) : acc_t'(quo_q);
        if (quot > acc_t'(DATA_MAX)) begin
            sat = DATA_MAX;
        end else if (quot < acc_t'(DATA_MIN)) begin
            sat = DATA_MIN;
        end else begin
            sat = data_t'(quot);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= S_IDLE;
            rd_addr <= '0;
            lane_q <= '0;
            step_q <= '0;
            out_valid <= 1'b0;
            row_done <= 1'b0;
        end else begin
            row_done <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (row_go) begin
                        rd_addr <= '0;
                        state_q <= S_READ;
                    end
                end
                // Wait out the buffer read latency
                S_READ: begin
                    lane_q <= '0;
                    step_q <= '0;
                    state_q <= S_DIV;
                end
                S_DIV: begin
                    if (step_q == 5'(DIV_STEPS - 1)) begin
                        step_q <= '0;
                        if (lane_q == LW'(LANES - 1)) begin
                            out_valid <= 1'b1;
                            state_q <= S_OUT;
                        end else begin
                            lane_q <= lane_q + 1'b1;
                        end
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                S_OUT: begin
                    if (out_ready) begin
                        out_valid <= 1'b0;
                        if (rd_addr == AW'(DEPTH - 1)) begin
                            row_done <= 1'b1;
                            state_q <= S_IDLE;
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                            state_q <= S_READ;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (row_go && state_q == S_IDLE) begin
            center_q <= center;
            scale_q <= scale;
        end
        if (state_q == S_DIV) begin
            if (step_q == '0) begin
                neg_q <= diff[QW-1];
                quo_q <= diff[QW-1] ? -diff : diff;
                rem_q <= '0;
            end else if (step_q == 5'(DIV_STEPS - 1)) begin
                out_data[lane_q] <= sat;
            end else if (rem_sh >= {1'b0, scale_q}) begin
                rem_q <= rem_sh - {1'b0, scale_q};
                quo_q <= {quo_q[QW-2:0], 1'b1};
            end else begin
                rem_q <= rem_sh;
                quo_q <= {quo_q[QW-2:0], 1'b0};
            end
        end
    end

endmodule

// File: hdl/norm.sv
/*
 * Row normalizer, LAYER_NORM or RMS_NORM, no affine weights
 * ROW_LEN is a power of two and LANES divides it
 * One row is in flight at a time, input stalls until the row is emitted
 */
module norm
    import norm_pkg::*;
#(
    parameter int ROW_LEN = 8,
    parameter int LANES = 2,
    parameter NORM_TYPE = "LAYER_NORM",
    localparam int DEPTH = ROW_LEN / LANES,
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic              clk,
    input  logic              arst_n,
    input  data_t [LANES-1:0] in_data,
    input  logic              in_valid,
    output logic              in_ready,
    output data_t [LANES-1:0] out_data,
    output logic              out_valid,
    input  logic              out_ready
);

    norm_state_t state_q;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;
    logic in_fire;
    logic last_beat;
    data_t [LANES-1:0] rd_data;
    logic stats_valid;
    stats_t stats;
    logic root_done;
    root_t root;
    root_t scale;
    logic row_go;
    logic row_done;

    assign in_ready = (state_q == IDLE) || (state_q == LOAD);
    assign in_fire = in_valid && in_ready;
    assign last_beat = in_fire && (wr_addr == AW'(DEPTH - 1));
    // Offset by one so the divisor is never zero
    assign scale = root + 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            wr_addr <= '0;
            row_go <= 1'b0;
        end else begin
            row_go <= 1'b0;
            if (in_fire) begin
                wr_addr <= last_beat ? '0 : wr_addr + 1'b1;
            end
            case (state_q)
                IDLE: begin
                    if (in_fire) begin
                        state_q <= last_beat ? ROOT : LOAD;
                    end
                end
                LOAD: begin
                    if (last_beat) begin
                        state_q <= ROOT;
                    end
                end
                // Stats and root run back to back here
                ROOT: begin
                    if (root_done) begin
                        row_go <= 1'b1;
                        state_q <= EMIT;
                    end
                end
                EMIT: begin
                    if (row_done) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    norm_row_buffer #(
        .ROW_LEN(ROW_LEN),
        .LANES(LANES)
    ) u_buffer (
        .clk(clk),
        .arst_n(arst_n),
        .wr_en(in_fire),
        .wr_addr(wr_addr),
        .rd_addr(rd_addr),
        .wr_data(in_data),
        .rd_data(rd_data)
    );

    norm_stats #(
        .ROW_LEN(ROW_LEN),
        .LANES(LANES),
        .NORM_TYPE(NORM_TYPE)
    ) u_stats (
        .clk(clk),
        .arst_n(arst_n),
        .beat_valid(in_fire),
        .beat(in_data),
        .last(last_beat),
        .stats_valid(stats_valid),
        .stats(stats)
    );

    norm_isqrt u_isqrt (
        .clk(clk),
        .arst_n(arst_n),
        .start(stats_valid),
        .radicand(stats.spread),
        .done(root_done),
        .root(root)
    );

    norm_scale #(
        .ROW_LEN(ROW_LEN),
        .LANES(LANES)
    ) u_scale (
        .clk(clk),
        .arst_n(arst_n),
        .row_go(row_go),
        .center(stats.center),
        .scale(scale),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .row_done(row_done)
    );

endmodule

// File: verification/norm_chk.sv
/*
 * Handshake assertions for the row normalizer, bound into norm
 * Inactive while arst_n is low
 */
module norm_chk
    import norm_pkg::*;
#(
    parameter int LANES = 2
) (
    input logic              clk,
    input logic              arst_n,
    input data_t [LANES-1:0] in_data,
    input logic              in_valid,
    input logic              in_ready,
    input data_t [LANES-1:0] out_data,
    input logic              out_valid,
    input logic              out_ready
);

    int assert_errors = 0;

    // Input beat holds until accepted
    in_hold: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
    else begin
        $error("in_valid dropped or in_data changed before acceptance");
        assert_errors++;
    end

    // Output beat holds until accepted
    out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
        $error("out_valid dropped or out_data changed before acceptance");
        assert_errors++;
    end

    // No new row is accepted while an output beat is pending
    busy_stall: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> !in_ready)
    else begin
        $error("in_ready high while an output beat is pending");
        assert_errors++;
    end

endmodule

bind norm norm_chk #(
    .LANES(LANES)
) u_chk (
    .clk(clk),
    .arst_n(arst_n),
    .in_data(in_data),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .out_data(out_data),
    .out_valid(out_valid),
    .out_ready(out_ready)
);

// File: verification/tb_norm.sv
/*
 * Testbench for the row normalizer with random rows from a fixed seed
 * Expected beats come from an integer model of the normalization rules
 * NORM_TYPE below must match the DUT parameter for the model to hold
 */
module tb_norm;
    import norm_pkg::*;

    localparam int ROW_LEN = 8;
    localparam int LANES = 2;
    localparam NORM_TYPE = "LAYER_NORM";
    localparam int BEATS = ROW_LEN / LANES;
    localparam int SHIFT = $clog2(ROW_LEN);
    localparam int WAIT_LIMIT = 2000;
    localparam int RX_LIMIT = 200000;
    localparam int RANDOM_ROWS = 40;

    typedef data_t [LANES-1:0] beat_t;

    logic clk;
    logic arst_n;
    beat_t in_data;
    logic in_valid;
    logic in_ready;
    beat_t out_data;
    logic out_valid;
    logic out_ready;

    beat_t exp_q[$];
    data_t row[ROW_LEN];
    int errors;
    int beats_seen;
    int rows_sent;
    int stall_pct;
    int sat_hi;
    int sat_lo;
    logic rx_stop;

    norm #(
        .ROW_LEN(ROW_LEN),
        .LANES(LANES),
        .NORM_TYPE(NORM_TYPE)
    ) DUT (
        .clk(clk),
        .arst_n(arst_n),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    always #50 clk = ~clk;

    task automatic check_element(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("errors: %0d, beats checked: %0d", errors, beats_seen);
        $display("RESULT: FAIL");
        $finish;
    endtask

    function automatic int floor_sqrt(input int v);
        int r;
        r = 0;
        while ((r + 1) * (r + 1) <= v) begin
            r++;
        end
        return r;
    endfunction

    // Expected beats for the row held in row[]
    task automatic model_row();
        int sum;
        int sq;
        int center;
        int spread;
        int scale;
        int q;
        beat_t b;
        sum = 0;
        sq = 0;
        for (int i = 0; i < ROW_LEN; i++) begin
            sum += int'(row[i]);
            sq += int'(row[i]) * int'(row[i]);
        end
        if (NORM_TYPE == "RMS_NORM") begin
            center = 0;
            spread = sq >>> SHIFT;
        end else begin
            center = sum >>> SHIFT;
            spread = (sq >>> SHIFT) - center * center;
            if (spread < 0) begin
                spread = 0;
            end
        end
        scale = floor_sqrt(spread) + 1;
        for (int i = 0; i < ROW_LEN; i++) begin
            // Integer division truncates toward zero
            q = ((int'(row[i]) - center) * 16) / scale;
            if (q > 127) begin
                q = 127;
            end else if (q < -128) begin
                q = -128;
            end
            b[i % LANES] = data_t'(q);
            if (i % LANES == LANES - 1) begin
                exp_q.push_back(b);
            end
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < ROW_LEN; i++) begin
            row[i] = data_t'($urandom & 32'hff);
        end
    endtask

    // All elements equal to base except one outlier
    task automatic fill_outlier(input data_t base, input data_t odd, input int pos);
        for (int i = 0; i < ROW_LEN; i++) begin
            row[i] = (i == pos) ? odd : base;
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic send_row();
        model_row();
        rows_sent++;
        for (int b = 0; b < BEATS; b++) begin
            int n;
            for (int l = 0; l < LANES; l++) begin
                in_data[l] = row[b * LANES + l];
            end
            in_valid = 1'b1;
            n = 0;
            while (!in_ready && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (!in_ready) begin
                abort_run("input beat was never accepted");
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic receive_beats();
        int cycles;
        beat_t exp;
        cycles = 0;
        while (!rx_stop && cycles < RX_LIMIT) begin
            @(negedge clk);
            cycles++;
            out_ready = (($urandom % 100) >= stall_pct);
            if (out_valid && out_ready) begin
                beats_seen++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Output beat 0x%h arrived with no row pending", out_data);
                end else begin
                    exp = exp_q.pop_front();
                    for (int l = 0; l < LANES; l++) begin
                        check_element($sformatf("out_data[%0d] beat %0d", l, beats_seen - 1),
                                      out_data[l], exp[l]);
                        if (out_data[l] == 8'sh7f) begin
                            sat_hi++;
                        end
                        if (out_data[l] == 8'sh80) begin
                            sat_lo++;
                        end
                    end
                end
            end
        end
    endtask

    initial begin
        int n;
        void'($urandom(32'hccc2_e167));
        clk = 1'b0;
        arst_n = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        stall_pct = 0;
        rx_stop = 1'b0;
        errors = 0;
        beats_seen = 0;
        rows_sent = 0;
        sat_hi = 0;
        sat_lo = 0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);

        fork
            receive_beats();
        join_none

        // Constant rows, zero spread
        fill_outlier(8'sd37, 8'sd37, 0);
        send_row();
        fill_outlier(-8'sd90, -8'sd90, 0);
        send_row();
        // Floored mean drives the variance to zero, outlier saturates
        fill_outlier(-8'sd128, -8'sd119, 5);
        send_row();
        fill_outlier(-8'sd117, -8'sd128, 2);
        send_row();
        for (int r = 0; r < RANDOM_ROWS; r++) begin
            if (r == RANDOM_ROWS / 4) begin
                stall_pct = 40;
            end
            fill_random();
            send_row();
        end

        n = 0;
        while (exp_q.size() != 0 && n < 20 * WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            abort_run("expected output beats never arrived");
        end
        // Idle stretch to catch extra beats
        repeat (100) @(negedge clk);
        rx_stop = 1'b1;

        if (beats_seen != rows_sent * BEATS) begin
            errors++;
            $display("Received %0d output beats but %0d were sent", beats_seen,
                     rows_sent * BEATS);
        end
        if (sat_hi == 0 || sat_lo == 0) begin
            errors++;
            $display("Saturation to both limits was not exercised");
        end
        errors += DUT.u_chk.assert_errors;
        $display("errors: %0d (assertions %0d), beats checked: %0d, rows: %0d",
                 errors, DUT.u_chk.assert_errors, beats_seen, rows_sent);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
hdl/norm_pkg.sv
hdl/norm_row_buffer.sv
hdl/norm_stats.sv
hdl/norm_isqrt.sv
hdl/norm_scale.sv
hdl/norm.sv
verification/norm_chk.sv
verification/tb_norm.sv

// File: Bender.yml
package:
  name: norm

sources:
  - hdl/norm_pkg.sv
  - hdl/norm_row_buffer.sv
  - hdl/norm_stats.sv
  - hdl/norm_isqrt.sv
  - hdl/norm_scale.sv
  - hdl/norm.sv
  - target: simulation
    files:
      - verification/norm_chk.sv
      - verification/tb_norm.sv
